//--- Bender.yml
package:
  name: v06c_io

sources:
  - design/v06c_pkg.sv
  - design/cpu_access_if.sv
  - design/wb_bus_front.sv
  - design/edisk_mapper.sv
  - design/io_ports.sv
  - design/joystick_ports.sv
  - design/page_ram.sv
  - design/v06c_io_top.sv
  - target: test
    files:
      - tb/v06c_checker.sv
      - tb/tb_v06c_io.sv

//--- all.f
design/v06c_pkg.sv
design/cpu_access_if.sv
design/wb_bus_front.sv
design/edisk_mapper.sv
design/io_ports.sv
design/joystick_ports.sv
design/page_ram.sv
design/v06c_io_top.sv
tb/v06c_checker.sv
tb/tb_v06c_io.sv

//--- design/cpu_access_if.sv
`timescale 1ns/1ps

interface cpu_access_if
	import v06c_pkg::*;
();

	logic [CPU_ADDR_W-1:0] addr;
	logic [DATA_W-1:0]     wdata;
	logic                  we;
	logic                  io;
	logic                  stack;

	// One-cycle strobe per CPU access
	logic                  acc;

	// I/O read data back to the bus front
	logic [DATA_W-1:0]     io_rdata;

	modport front (
		output addr, wdata, we, io, stack, acc,
		input  io_rdata
	);

	modport block (
		input  addr, wdata, we, io, stack, acc,
		output io_rdata
	);

endinterface

//--- design/edisk_mapper.sv
`timescale 1ns/1ps

module edisk_mapper
	import v06c_pkg::*;
(
	input  logic              clk_sys,
	input  logic              cold_reset,
	cpu_access_if.block       acc_if,
	input  logic              edisk_we_i,
	output logic [PAGE_W-1:0] page_o
);

	logic [DATA_W-1:0] ed_reg;
	logic              a15;
	logic              a14;
	logic              a13;
	logic              in_window;
	logic              stack_hit;
	logic              window_hit;

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			ed_reg <= '0;
		end else if (edisk_we_i) begin
			ed_reg <= acc_if.wdata;
		end
	end

	// ----------------------------------------
	// Window decode
	// ----------------------------------------
	assign a15 = acc_if.addr[15];
	assign a14 = acc_if.addr[14];
	assign a13 = acc_if.addr[13];

	// A000-DFFF always, 8000-9FFF and E000-FFFF on their extend bits
	assign in_window = a15 & ((a14 ^ a13)
		| (ed_reg[ED_EXT_HI] & a14 & a13)
		| (ed_reg[ED_EXT_LO] & ~a14 & ~a13));

	assign stack_hit  = ~acc_if.io & acc_if.stack & ed_reg[ED_STK_EN];
	assign window_hit = ~acc_if.io & in_window & ed_reg[ED_WIN_EN];

	// Stack mapping wins over the window
	always_comb begin
		if (stack_hit) begin
			page_o = PAGE_W'(ed_reg[ED_STK_SEL_HI:ED_STK_SEL_LO]) + PAGE_W'(1);
		end else if (window_hit) begin
			page_o = PAGE_W'(ed_reg[ED_WIN_SEL_HI:ED_WIN_SEL_LO]) + PAGE_W'(1);
		end else begin
			page_o = '0;
		end
	end

endmodule

//--- design/io_ports.sv
`timescale 1ns/1ps

module io_ports
	import v06c_pkg::*;
(
	input  logic              clk_sys,
	input  logic              cold_reset,
	cpu_access_if.block       acc_if,
	input  logic [DATA_W-1:0] joy_sel_rdata_i,
	input  logic [DATA_W-1:0] joy_pu_rdata_i,
	input  logic [DATA_W-1:0] joy_a_rdata_i,
	input  logic [DATA_W-1:0] joy_b_rdata_i,
	output logic              edisk_we_o,
	output logic              joy_we_o,
	output logic [DATA_W-1:0] covox_o
);

	logic [7:0]        port_addr;
	logic              io_wr;
	logic              joy_ctrl_hit;
	logic              covox_we;
	logic [DATA_W-1:0] covox_q;

	// Only the low address byte counts in I/O space
	assign port_addr = acc_if.addr[7:0];
	assign io_wr     = acc_if.acc & acc_if.io & acc_if.we;

	// 04 and 05 both land on the joystick control
	assign joy_ctrl_hit = (port_addr[7:1] == PORT_JOY_CTRL[7:1]);

	// ----------------------------------------
	// Write strobes
	// ----------------------------------------
	assign edisk_we_o = io_wr & (port_addr == PORT_EDISK);
	assign joy_we_o   = io_wr & joy_ctrl_hit;
	assign covox_we   = io_wr & (port_addr == PORT_JOY_PU_COVOX);

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			covox_q <= '0;
		end else if (covox_we) begin
			covox_q <= acc_if.wdata;
		end
	end

	assign covox_o = covox_q;

	// ----------------------------------------
	// Read multiplexer
	// ----------------------------------------
	always_comb begin
		if (joy_ctrl_hit) begin
			// Control register is write only, reads give zero
			acc_if.io_rdata = '0;
		end else begin
			case (port_addr)
				PORT_JOY_SEL:      acc_if.io_rdata = joy_sel_rdata_i;
				PORT_JOY_PU_COVOX: acc_if.io_rdata = joy_pu_rdata_i;
				PORT_JOY_A:        acc_if.io_rdata = joy_a_rdata_i;
				PORT_JOY_B:        acc_if.io_rdata = joy_b_rdata_i;
				default:           acc_if.io_rdata = IO_IDLE_DATA;
			endcase
		end
	end

endmodule

//--- design/joystick_ports.sv
`timescale 1ns/1ps

module joystick_ports
	import v06c_pkg::*;
(
	input  logic              clk_sys,
	input  logic              cold_reset,
	cpu_access_if.block       acc_if,
	input  logic              joy_we_i,
	input  logic [JOY_W-1:0]  joy_a_i,
	input  logic [JOY_W-1:0]  joy_b_i,
	output logic [DATA_W-1:0] sel_rdata_o,
	output logic [DATA_W-1:0] pu_rdata_o,
	output logic [DATA_W-1:0] a_rdata_o,
	output logic [DATA_W-1:0] b_rdata_o
);

	logic [DATA_W-1:0] joy_reg;
	logic [JOY_W-1:0]  joy_pu;

	// Active-low port byte, buttons 2 and 3 swap places
	function automatic logic [DATA_W-1:0] joy_pack(input logic [JOY_W-1:0] btn);
		return ~{btn[5], btn[4], 2'b00, btn[2], btn[3], btn[1], btn[0]};
	endfunction

	// ----------------------------------------
	// Control register
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			joy_reg <= '0;
		end else if (joy_we_i) begin
			if (acc_if.addr[0]) begin
				joy_reg <= acc_if.wdata;
			end else if (!acc_if.wdata[7]) begin
				// Single bit set/reset
				joy_reg[acc_if.wdata[3:1]] <= acc_if.wdata[0];
			end
		end
	end

	assign a_rdata_o = joy_pack(joy_a_i);
	assign b_rdata_o = joy_pack(joy_b_i);

	// Either stick
	assign joy_pu     = joy_a_i | joy_b_i;
	assign pu_rdata_o = {joy_pu[3], joy_pu[0], joy_pu[2], joy_pu[1],
		joy_pu[4], joy_pu[5], 2'b00};

	always_comb begin
		case (joy_reg[6:5])
			2'b00:   sel_rdata_o = a_rdata_o & b_rdata_o;
			2'b01:   sel_rdata_o = a_rdata_o;
			2'b10:   sel_rdata_o = b_rdata_o;
			default: sel_rdata_o = 8'hFF;
		endcase
	end

endmodule

//--- design/page_ram.sv
`timescale 1ns/1ps

module page_ram
	import v06c_pkg::*;
(
	input  logic              clk_sys,
	cpu_access_if.block       acc_if,
	input  logic [PAGE_W-1:0] page_i,
	output logic [DATA_W-1:0] rdata_o
);

	localparam int DEPTH = NUM_PAGES * (1 << CPU_ADDR_W);

	logic [DATA_W-1:0]     mem [DEPTH];
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  ram_we;

	// Page on top of the CPU address
	assign ram_addr = {page_i, acc_if.addr};
	assign ram_we   = acc_if.acc & ~acc_if.io & acc_if.we;

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= acc_if.wdata;
		end
		rdata_o <= mem[ram_addr];
	end

endmodule

//--- design/v06c_io_top.sv
`timescale 1ns/1ps

module v06c_io_top
	import v06c_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  cold_reset,

	// Wishbone classic slave
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic [CPU_ADDR_W-1:0] wb_adr_i,
	input  logic [DATA_W-1:0]     wb_dat_i,
	output logic [DATA_W-1:0]     wb_dat_o,
	output logic                  wb_ack_o,

	// Cycle tags
	input  logic                  wb_io_i,
	input  logic                  wb_stack_i,

	input  logic [JOY_W-1:0]      joy_a_i,
	input  logic [JOY_W-1:0]      joy_b_i,
	output logic [DATA_W-1:0]     covox_o
);

	logic [DATA_W-1:0] ram_rdata;
	logic [PAGE_W-1:0] page;
	logic              edisk_we;
	logic              joy_we;
	logic [DATA_W-1:0] joy_sel_rdata;
	logic [DATA_W-1:0] joy_pu_rdata;
	logic [DATA_W-1:0] joy_a_rdata;
	logic [DATA_W-1:0] joy_b_rdata;

	cpu_access_if acc_if ();

	wb_bus_front u_front (
		.clk_sys     (clk_sys),
		.cold_reset  (cold_reset),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_we_i     (wb_we_i),
		.wb_adr_i    (wb_adr_i),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.wb_io_i     (wb_io_i),
		.wb_stack_i  (wb_stack_i),
		.acc_if      (acc_if.front),
		.ram_rdata_i (ram_rdata)
	);

	io_ports u_io (
		.clk_sys         (clk_sys),
		.cold_reset      (cold_reset),
		.acc_if          (acc_if.block),
		.joy_sel_rdata_i (joy_sel_rdata),
		.joy_pu_rdata_i  (joy_pu_rdata),
		.joy_a_rdata_i   (joy_a_rdata),
		.joy_b_rdata_i   (joy_b_rdata),
		.edisk_we_o      (edisk_we),
		.joy_we_o        (joy_we),
		.covox_o         (covox_o)
	);

	edisk_mapper u_edisk (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.acc_if     (acc_if.block),
		.edisk_we_i (edisk_we),
		.page_o     (page)
	);

	joystick_ports u_joy (
		.clk_sys     (clk_sys),
		.cold_reset  (cold_reset),
		.acc_if      (acc_if.block),
		.joy_we_i    (joy_we),
		.joy_a_i     (joy_a_i),
		.joy_b_i     (joy_b_i),
		.sel_rdata_o (joy_sel_rdata),
		.pu_rdata_o  (joy_pu_rdata),
		.a_rdata_o   (joy_a_rdata),
		.b_rdata_o   (joy_b_rdata)
	);

	page_ram u_ram (
		.clk_sys (clk_sys),
		.acc_if  (acc_if.block),
		.page_i  (page),
		.rdata_o (ram_rdata)
	);

endmodule

//--- design/v06c_pkg.sv
package v06c_pkg;

	// ----------------------------------------
	// Bus and memory widths
	// ----------------------------------------
	localparam int CPU_ADDR_W = 16;
	localparam int DATA_W     = 8;
	localparam int PAGE_W     = 3;
	localparam int NUM_PAGES  = 5;
	localparam int RAM_ADDR_W = PAGE_W + CPU_ADDR_W;
	localparam int JOY_W      = 6;

	// ----------------------------------------
	// I/O port codes
	// ----------------------------------------
	// Joystick control answers at 04 and 05, bit 0 picks the write mode
	typedef enum logic [7:0] {
		PORT_JOY_CTRL     = 8'h04,
		PORT_JOY_SEL      = 8'h06,
		PORT_JOY_PU_COVOX = 8'h07,
		PORT_JOY_A        = 8'h0E,
		PORT_JOY_B        = 8'h0F,
		PORT_EDISK        = 8'h10
	} io_port_e;

	// Value returned by ports nobody answers
	localparam logic [DATA_W-1:0] IO_IDLE_DATA = 8'hFF;

	// ----------------------------------------
	// E-disk control register layout
	// ----------------------------------------
	// Window page select
	localparam int ED_WIN_SEL_LO = 0;
	localparam int ED_WIN_SEL_HI = 1;

	// Stack page select
	localparam int ED_STK_SEL_LO = 2;
	localparam int ED_STK_SEL_HI = 3;

	localparam int ED_STK_EN = 4;
	localparam int ED_WIN_EN = 5;

	// Window extends to 8000-9FFF / E000-FFFF
	localparam int ED_EXT_LO = 6;
	localparam int ED_EXT_HI = 7;

endpackage

//--- design/wb_bus_front.sv
`timescale 1ns/1ps

module wb_bus_front
	import v06c_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  cold_reset,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic [CPU_ADDR_W-1:0] wb_adr_i,
	input  logic [DATA_W-1:0]     wb_dat_i,
	output logic [DATA_W-1:0]     wb_dat_o,
	output logic                  wb_ack_o,
	input  logic                  wb_io_i,
	input  logic                  wb_stack_i,
	cpu_access_if.front           acc_if,
	input  logic [DATA_W-1:0]     ram_rdata_i
);

	// Phase 0 idle, 1 RAM data out, 2 read data held, 3 ack
	logic [1:0]        phase;
	logic              io_q;
	logic [DATA_W-1:0] rdata_q;

	// Master keeps everything stable until ack, so pass it straight on
	assign acc_if.addr  = wb_adr_i;
	assign acc_if.wdata = wb_dat_i;
	assign acc_if.we    = wb_we_i;
	assign acc_if.io    = wb_io_i;
	assign acc_if.stack = wb_stack_i;

	// Only taken from idle, never while ack is up
	assign acc_if.acc = wb_cyc_i & wb_stb_i & (phase == 2'd0);

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			phase <= 2'd0;
			io_q  <= 1'b0;
		end else if (acc_if.acc) begin
			phase <= 2'd1;
			io_q  <= wb_io_i;
		end else if (phase != 2'd0) begin
			// Wraps from ack back to idle
			phase <= phase + 2'd1;
		end
	end

	// ----------------------------------------
	// Read data path
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (phase == 2'd1) begin
			rdata_q <= io_q ? acc_if.io_rdata : ram_rdata_i;
		end
	end

	assign wb_dat_o = rdata_q;
	assign wb_ack_o = (phase == 2'd3);

endmodule

//--- tb/tb_v06c_io.sv
`timescale 1ns/1ps

module tb_v06c_io
	import v06c_pkg::*;
();

	localparam int HALF_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;

	typedef struct {
		logic                  io;
		logic                  stack;
		logic                  we;
		logic [CPU_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     wdata;
		logic [JOY_W-1:0]      joy_a;
		logic [JOY_W-1:0]      joy_b;
		logic [DATA_W-1:0]     exp_data;
		logic                  cmp;
	} entry_t;

	logic                  clk_sys;
	logic                  cold_reset;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [CPU_ADDR_W-1:0] wb_adr;
	logic [DATA_W-1:0]     wb_dat_w;
	logic [DATA_W-1:0]     wb_dat_r;
	logic                  wb_ack;
	logic                  wb_io;
	logic                  wb_stack;
	logic [JOY_W-1:0]      joy_a;
	logic [JOY_W-1:0]      joy_b;
	logic [DATA_W-1:0]     covox;

	entry_t            tests[$];
	logic [DATA_W-1:0] rnd [12];
	logic [DATA_W-1:0] joy_model;
	int                test_idx;
	logic [DATA_W-1:0] exp_data;
	logic              cmp_en;
	logic [DATA_W-1:0] exp_covox;
	int                done_count;
	int                fail_count;
	int                error_count;
	int                cycle_count = 0;
	int                timeout_limit = 0;

	v06c_io_top dut (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.wb_cyc_i   (wb_cyc),
		.wb_stb_i   (wb_stb),
		.wb_we_i    (wb_we),
		.wb_adr_i   (wb_adr),
		.wb_dat_i   (wb_dat_w),
		.wb_dat_o   (wb_dat_r),
		.wb_ack_o   (wb_ack),
		.wb_io_i    (wb_io),
		.wb_stack_i (wb_stack),
		.joy_a_i    (joy_a),
		.joy_b_i    (joy_b),
		.covox_o    (covox)
	);

	v06c_checker u_checker (
		.clk_sys       (clk_sys),
		.cold_reset    (cold_reset),
		.wb_cyc_i      (wb_cyc),
		.wb_stb_i      (wb_stb),
		.wb_ack_i      (wb_ack),
		.wb_dat_i      (wb_dat_r),
		.covox_i       (covox),
		.test_idx_i    (test_idx),
		.exp_data_i    (exp_data),
		.cmp_en_i      (cmp_en),
		.exp_covox_i   (exp_covox),
		.done_count_o  (done_count),
		.fail_count_o  (fail_count),
		.error_count_o (error_count)
	);

	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			$display("Timeout: run stopped after %0d cycles", cycle_count);
			$display("Finished with errors");
			$finish;
		end
	end

	// ----------------------------------------
	// Expected values from the port rules
	// ----------------------------------------
	// Active low, buttons 2 and 3 trade places
	function automatic logic [DATA_W-1:0] joy_byte(input logic [JOY_W-1:0] btn);
		return ~{btn[5], btn[4], 1'b0, 1'b0, btn[2], btn[3], btn[1], btn[0]};
	endfunction

	function automatic logic [DATA_W-1:0] joy_combined(input logic [JOY_W-1:0] a,
		input logic [JOY_W-1:0] b);
		logic [JOY_W-1:0] p;
		p = a | b;
		return {p[3], p[0], p[2], p[1], p[4], p[5], 2'b00};
	endfunction

	function automatic logic [DATA_W-1:0] joy_selected(input logic [JOY_W-1:0] a,
		input logic [JOY_W-1:0] b);
		case (joy_model[6:5])
			2'b00:   return joy_byte(a) & joy_byte(b);
			2'b01:   return joy_byte(a);
			2'b10:   return joy_byte(b);
			default: return 8'hFF;
		endcase
	endfunction

	task automatic add_entry(input logic io, input logic stack, input logic we,
		input logic [15:0] addr, input logic [7:0] wdata, input logic [5:0] ja,
		input logic [5:0] jb, input logic [7:0] exp_val, input logic cmp);
		tests.push_back('{io, stack, we, addr, wdata, ja, jb, exp_val, cmp});
	endtask

	task automatic mem_wr(input logic [15:0] addr, input logic [7:0] data, input logic stack);
		add_entry(1'b0, stack, 1'b1, addr, data, '0, '0, '0, 1'b0);
	endtask

	task automatic mem_rd(input logic [15:0] addr, input logic [7:0] exp_val,
		input logic stack);
		add_entry(1'b0, stack, 1'b0, addr, '0, '0, '0, exp_val, 1'b1);
	endtask

	// Tracks the joystick control register as the writes go in
	task automatic io_wr(input logic [15:0] addr, input logic [7:0] data);
		if (addr[7:0] == 8'h05) begin
			joy_model = data;
		end else if (addr[7:0] == 8'h04 && !data[7]) begin
			joy_model[data[3:1]] = data[0];
		end
		add_entry(1'b1, 1'b0, 1'b1, addr, data, '0, '0, '0, 1'b0);
	endtask

	task automatic io_rd(input logic [15:0] addr, input logic [5:0] ja, input logic [5:0] jb,
		input logic [7:0] exp_val);
		add_entry(1'b1, 1'b0, 1'b0, addr, '0, ja, jb, exp_val, 1'b1);
	endtask

	task automatic build_tests();
		joy_model = '0;
		mem_wr(16'h0123, rnd[0], 1'b0);
		mem_wr(16'h7FFE, rnd[1], 1'b0);
		mem_wr(16'hB000, rnd[2], 1'b0);
		mem_wr(16'hE000, rnd[3], 1'b0);
		mem_wr(16'h8000, rnd[4], 1'b0);
		mem_wr(16'h1000, rnd[5], 1'b0);
		mem_rd(16'h0123, rnd[0], 1'b0);
		mem_rd(16'h7FFE, rnd[1], 1'b0);
		// Window on page 3
		io_wr(16'h0010, 8'h22);
		mem_wr(16'hB000, rnd[6], 1'b0);
		io_wr(16'h5A10, 8'h00);
		mem_rd(16'hB000, rnd[2], 1'b0);
		io_wr(16'h0010, 8'h22);
		mem_rd(16'hB000, rnd[6], 1'b0);
		mem_rd(16'hE000, rnd[3], 1'b0);
		io_wr(16'h0010, 8'hA2);
		mem_wr(16'hE000, rnd[7], 1'b0);
		mem_rd(16'hE000, rnd[7], 1'b0);
		io_wr(16'h0010, 8'h62);
		mem_rd(16'hE000, rnd[3], 1'b0);
		mem_wr(16'h8000, rnd[8], 1'b0);
		io_wr(16'h0010, 8'h22);
		mem_rd(16'h8000, rnd[4], 1'b0);
		io_wr(16'h0010, 8'h62);
		mem_rd(16'h8000, rnd[8], 1'b0);
		// Stack on page 4, window on page 2
		io_wr(16'h0010, 8'h3D);
		mem_wr(16'hC000, rnd[9], 1'b1);
		mem_wr(16'hC000, rnd[10], 1'b0);
		mem_wr(16'h1000, rnd[11], 1'b1);
		mem_rd(16'hC000, rnd[9], 1'b1);
		mem_rd(16'hC000, rnd[10], 1'b0);
		mem_rd(16'h1000, rnd[5], 1'b0);
		mem_rd(16'h1000, rnd[11], 1'b1);
		io_wr(16'h0010, 8'h21);
		mem_rd(16'hC000, rnd[10], 1'b1);
		// Joystick ports, patterns 15, 26 and 38 give every button its own code
		io_rd(16'h000E, 6'h15, 6'h26, joy_byte(6'h15));
		io_rd(16'h000F, 6'h15, 6'h26, joy_byte(6'h26));
		io_rd(16'h000E, 6'h26, 6'h38, joy_byte(6'h26));
		io_rd(16'h000F, 6'h26, 6'h38, joy_byte(6'h38));
		io_rd(16'h000E, 6'h38, 6'h15, joy_byte(6'h38));
		io_rd(16'h000F, 6'h38, 6'h15, joy_byte(6'h15));
		io_rd(16'h0006, 6'h15, 6'h2A, joy_selected(6'h15, 6'h2A));
		io_rd(16'h0007, 6'h15, 6'h00, joy_combined(6'h15, 6'h00));
		io_rd(16'h0007, 6'h00, 6'h26, joy_combined(6'h00, 6'h26));
		io_wr(16'h0005, 8'h20);
		io_rd(16'h0006, 6'h09, 6'h30, joy_selected(6'h09, 6'h30));
		io_wr(16'h0004, 8'h0D);
		io_rd(16'h0006, 6'h09, 6'h30, joy_selected(6'h09, 6'h30));
		io_wr(16'h0004, 8'h0A);
		io_rd(16'h0006, 6'h09, 6'h30, joy_selected(6'h09, 6'h30));
		io_wr(16'h0004, 8'h8D);
		io_rd(16'h0006, 6'h22, 6'h11, joy_selected(6'h22, 6'h11));
		io_rd(16'h0007, 6'h18, 6'h20, joy_combined(6'h18, 6'h20));
		// Covox and unmapped ports
		io_wr(16'h0007, 8'h5C);
		io_rd(16'h0004, 6'h00, 6'h00, 8'h00);
		io_rd(16'h0005, 6'h00, 6'h00, 8'h00);
		io_rd(16'h0000, 6'h00, 6'h00, 8'hFF);
		io_rd(16'h001A, 6'h00, 6'h00, 8'hFF);
		io_wr(16'h1207, 8'hA3);
		io_rd(16'h0010, 6'h00, 6'h00, 8'hFF);
	endtask

	// ----------------------------------------
	// Reset, then one Wishbone cycle per entry
	// ----------------------------------------
	initial begin
		cold_reset = 1'b1;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		wb_io      = 1'b0;
		wb_stack   = 1'b0;
		joy_a      = '0;
		joy_b      = '0;
		test_idx   = 0;
		exp_data   = '0;
		cmp_en     = 1'b0;
		exp_covox  = '0;
		void'($urandom(40));
		foreach (rnd[k]) begin
			rnd[k] = 8'($urandom);
		end
		build_tests();
		timeout_limit = tests.size() * 4 + 20;

		repeat (3) @(posedge clk_sys);
		#DRIVE_DELAY;
		cold_reset = 1'b0;

		foreach (tests[i]) begin
			@(posedge clk_sys);
			#DRIVE_DELAY;
			test_idx = i;
			wb_io    = tests[i].io;
			wb_stack = tests[i].stack;
			wb_we    = tests[i].we;
			wb_adr   = tests[i].addr;
			wb_dat_w = tests[i].wdata;
			joy_a    = tests[i].joy_a;
			joy_b    = tests[i].joy_b;
			exp_data = tests[i].exp_data;
			cmp_en   = tests[i].cmp;
			// Covox takes the data of any I/O write to port 07
			if (tests[i].io && tests[i].we && tests[i].addr[7:0] == 8'h07) begin
				exp_covox = tests[i].wdata;
			end
			wb_cyc = 1'b1;
			wb_stb = 1'b1;
			do begin
				@(posedge clk_sys);
				#DRIVE_DELAY;
			end while (wb_ack !== 1'b1);
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
		end

		repeat (2) @(posedge clk_sys);
		$display("Tests run: %0d, failed: %0d, errors: %0d", done_count, fail_count,
			error_count);
		if (error_count == 0 && done_count == tests.size()) begin
			$display("Finished with no errors");
		end else begin
			if (done_count != tests.size()) begin
				$display("Only %0d of %0d tests were completed", done_count, tests.size());
			end
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- tb/v06c_checker.sv
`timescale 1ns/1ps

module v06c_checker
	import v06c_pkg::*;
(
	input  logic              clk_sys,
	input  logic              cold_reset,
	input  logic              wb_cyc_i,
	input  logic              wb_stb_i,
	input  logic              wb_ack_i,
	input  logic [DATA_W-1:0] wb_dat_i,
	input  logic [DATA_W-1:0] covox_i,
	input  int                test_idx_i,
	input  logic [DATA_W-1:0] exp_data_i,
	input  logic              cmp_en_i,
	input  logic [DATA_W-1:0] exp_covox_i,
	output int                done_count_o,
	output int                fail_count_o,
	output int                error_count_o
);

	int   wait_cycles;
	int   test_errors;
	logic busy;
	logic ack_prev;
	logic reset_checked;

	task automatic count_error();
		error_count_o++;
		test_errors++;
	endtask

	task automatic close_test();
		done_count_o++;
		if (test_errors == 0) begin
			$display("Test %0d passed", test_idx_i);
		end else begin
			fail_count_o++;
			$display("Test %0d failed with %0d errors", test_idx_i, test_errors);
		end
	endtask

	// Falling edge, so every DUT output has settled
	always @(negedge clk_sys) begin
		if (cold_reset) begin
			busy          = 1'b0;
			reset_checked = 1'b0;
			done_count_o  = 0;
			fail_count_o  = 0;
			error_count_o = 0;
		end else if (!reset_checked) begin
			reset_checked = 1'b1;
			test_errors   = 0;
			if (wb_ack_i !== 1'b0) begin
				$display("Ack is not low after reset");
				count_error();
			end
			if (covox_i !== 8'h00) begin
				$display("Mismatch after reset: covox_o expected 0x00, got 0x%02h", covox_i);
				count_error();
			end
			$display("Reset check %s", (test_errors == 0) ? "passed" : "failed");
		end else if (busy) begin
			wait_cycles++;
			if (wb_ack_i === 1'b1) begin
				// Third falling edge is two cycles after the accepting edge
				if (wait_cycles != 3) begin
					$display("Test %0d: ack came %0d cycles after the request was taken, not 2",
						test_idx_i, wait_cycles - 1);
					count_error();
				end
				if (cmp_en_i && wb_dat_i !== exp_data_i) begin
					$display("Mismatch in test %0d: wb_dat_o expected 0x%02h, got 0x%02h",
						test_idx_i, exp_data_i, wb_dat_i);
					count_error();
				end
				if (covox_i !== exp_covox_i) begin
					$display("Mismatch in test %0d: covox_o expected 0x%02h, got 0x%02h",
						test_idx_i, exp_covox_i, covox_i);
					count_error();
				end
				close_test();
				busy = 1'b0;
			end else if (wait_cycles == 3) begin
				$display("Test %0d: no ack two cycles after the request", test_idx_i);
				count_error();
			end
		end else if (wb_ack_i === 1'b1) begin
			if (ack_prev) begin
				$display("Ack stayed high for more than one cycle");
			end else begin
				$display("Ack came without a request");
			end
			count_error();
		end else if (wb_cyc_i && wb_stb_i) begin
			busy        = 1'b1;
			wait_cycles = 0;
			test_errors = 0;
		end
		ack_prev = wb_ack_i;
	end

endmodule
